//--- soc_params.svh
// Peripheral subsystem parameters
// Bus widths, address map and GPIO widths shared by RTL and testbench

`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BE_W   4

// RAM window, 1 KiB
`define SOC_RAM_BASE   32'h0010_0000
`define SOC_RAM_SIZE   32'h0000_0400
`define SOC_RAM_MASK   (~(`SOC_RAM_SIZE - 32'd1))

`define SOC_GPIO_BASE  32'h8000_0000
`define SOC_GPIO_SIZE  32'h0000_1000  // 4 KiB
`define SOC_GPIO_MASK  (~(`SOC_GPIO_SIZE - 32'd1))

`define SOC_TIMER_BASE 32'h8000_2000
`define SOC_TIMER_SIZE 32'h0000_1000  // 4 KiB
`define SOC_TIMER_MASK (~(`SOC_TIMER_SIZE - 32'd1))

`define SOC_GPI_W 8
`define SOC_GPO_W 16

// Register offsets inside a 4 KiB window
`define SOC_REG_OFS_0 12'h000
`define SOC_REG_OFS_4 12'h004

`endif

//--- soc_pkg.sv
// Shared bus types for the peripheral subsystem
// Host request, host response and device select

`include "soc_params.svh"

package soc_pkg;

  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   we;
    logic [`SOC_BE_W-1:0]   be;
    logic [`SOC_DATA_W-1:0] wdata;
  } bus_req_t;  // 69 bits

  typedef struct packed {
    logic                   valid;
    logic                   err;
    logic [`SOC_DATA_W-1:0] rdata;
  } bus_rsp_t;  // 34 bits

  typedef struct packed {
    logic ram;
    logic gpio;
    logic timer;
    logic unmapped;
  } dev_sel_t;

  // Replace only the enabled bytes of a word
  function automatic logic [`SOC_DATA_W-1:0] be_merge(input logic [`SOC_DATA_W-1:0] old_w,
                                                       input logic [`SOC_DATA_W-1:0] new_w,
                                                       input logic [`SOC_BE_W-1:0]   be);
    logic [`SOC_DATA_W-1:0] res;
    res = old_w;
    for (int i = 0; i < `SOC_BE_W; i++) begin
      if (be[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

endpackage

//--- soc_addr_decode.sv
// Address decoder
// Base/mask compare per device window, one-hot select per host strobe
// Unmapped bit set when no window matches

`include "soc_params.svh"

module soc_addr_decode (
  input  logic               host_req_i,
  input  soc_pkg::bus_req_t  host_cmd_i,
  output soc_pkg::dev_sel_t  dev_sel_o
);

  logic [`SOC_ADDR_W-1:0] addr;
  logic                   ram_hit;
  logic                   gpio_hit;
  logic                   timer_hit;
  logic                   any_hit;

  assign addr = host_cmd_i.addr;

  assign ram_hit   = (addr & `SOC_RAM_MASK) == `SOC_RAM_BASE;
  assign gpio_hit  = (addr & `SOC_GPIO_MASK) == `SOC_GPIO_BASE;
  assign timer_hit = (addr & `SOC_TIMER_MASK) == `SOC_TIMER_BASE;

  // Windows never overlap
  assign any_hit = ram_hit | gpio_hit | timer_hit;

  always_comb begin
    dev_sel_o          = '0;
    dev_sel_o.ram      = host_req_i & ram_hit;
    dev_sel_o.gpio     = host_req_i & gpio_hit;
    dev_sel_o.timer    = host_req_i & timer_hit;
    dev_sel_o.unmapped = host_req_i & ~any_hit;
  end

endmodule

//--- soc_ram.sv
// Single-port RAM, 256 words
// Byte-enabled writes, read data registered for one cycle

`include "soc_params.svh"

module soc_ram (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  logic                   req_i,
  input  soc_pkg::bus_req_t      cmd_i,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  localparam int Depth = `SOC_RAM_SIZE / 4;
  localparam int IdxW  = $clog2(Depth);

  logic [`SOC_DATA_W-1:0] mem [Depth];
  logic [IdxW-1:0]        idx;
  logic [`SOC_DATA_W-1:0] rdata_q;

  assign idx = cmd_i.addr[IdxW+1:2];  // word index

  always_ff @(posedge clk_sys_i) begin
    if (req_i && cmd_i.we) begin
      for (int i = 0; i < `SOC_BE_W; i++) begin
        if (cmd_i.be[i]) mem[idx][8*i +: 8] <= cmd_i.wdata[8*i +: 8];
      end
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= cmd_i.we ? '0 : mem[idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- soc_gpio.sv
// GPIO block
// Offset 0 is the output register, offset 4 the synchronised inputs

`include "soc_params.svh"

module soc_gpio (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  logic                   req_i,
  input  soc_pkg::bus_req_t      cmd_i,
  input  logic [`SOC_GPI_W-1:0]  gp_i,
  output logic [`SOC_GPO_W-1:0]  gp_o,
  output logic [`SOC_DATA_W-1:0] rdata_o
);

  logic [`SOC_GPO_W-1:0]  gpo_q;
  logic [`SOC_DATA_W-1:0] gpo_merged;
  logic [`SOC_GPI_W-1:0]  gpi_meta_q;
  logic [`SOC_GPI_W-1:0]  gpi_sync_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   sel_out;
  logic                   sel_in;

  assign sel_out = cmd_i.addr[11:0] == `SOC_REG_OFS_0;
  assign sel_in  = cmd_i.addr[11:0] == `SOC_REG_OFS_4;

  assign gpo_merged = soc_pkg::be_merge(`SOC_DATA_W'(gpo_q), cmd_i.wdata, cmd_i.be);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gpo_q      <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
      rdata_q    <= '0;
    end else begin
      gpi_meta_q <= gp_i;  // Two-flop sync
      gpi_sync_q <= gpi_meta_q;
      if (req_i && cmd_i.we && sel_out) gpo_q <= gpo_merged[`SOC_GPO_W-1:0];
      if (req_i) begin
        if (cmd_i.we)     rdata_q <= '0;
        else if (sel_out) rdata_q <= `SOC_DATA_W'(gpo_q);
        else if (sel_in)  rdata_q <= `SOC_DATA_W'(gpi_sync_q);
        else              rdata_q <= '0;
      end
    end
  end

  assign gp_o    = gpo_q;
  assign rdata_o = rdata_q;

endmodule

//--- soc_timer.sv
// Machine timer
// Free-running mtime with compare register, interrupt when mtime >= mtimecmp
// mtime at offset 0, mtimecmp at offset 4

`include "soc_params.svh"

module soc_timer (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  logic                   req_i,
  input  soc_pkg::bus_req_t      cmd_i,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   irq_o
);

  logic [`SOC_DATA_W-1:0] mtime_q;
  logic [`SOC_DATA_W-1:0] mtimecmp_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   irq_q;
  logic                   sel_time;
  logic                   sel_cmp;
  logic                   wr_time;
  logic                   wr_cmp;

  assign sel_time = cmd_i.addr[11:0] == `SOC_REG_OFS_0;
  assign sel_cmp  = cmd_i.addr[11:0] == `SOC_REG_OFS_4;
  assign wr_time  = req_i & cmd_i.we & sel_time;
  assign wr_cmp   = req_i & cmd_i.we & sel_cmp;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      // A write wins over the increment
      if (wr_time) mtime_q <= soc_pkg::be_merge(mtime_q, cmd_i.wdata, cmd_i.be);
      else         mtime_q <= mtime_q + 1'b1;
      if (wr_cmp) mtimecmp_q <= soc_pkg::be_merge(mtimecmp_q, cmd_i.wdata, cmd_i.be);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= mtime_q >= mtimecmp_q;  // one cycle behind the compare
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      if (cmd_i.we)      rdata_q <= '0;
      else if (sel_time) rdata_q <= mtime_q;
      else if (sel_cmp)  rdata_q <= mtimecmp_q;
      else               rdata_q <= '0;
    end
  end

  assign rdata_o = rdata_q;
  assign irq_o   = irq_q;

endmodule

//--- soc_rsp_mux.sv
// Response stage
// Registers the device select and builds the host response a cycle later

`include "soc_params.svh"

module soc_rsp_mux (
  input  logic                   clk_sys_i,
  input  logic                   rst_sys_ni,
  input  soc_pkg::dev_sel_t      dev_sel_i,
  input  logic [`SOC_DATA_W-1:0] ram_rdata_i,
  input  logic [`SOC_DATA_W-1:0] gpio_rdata_i,
  input  logic [`SOC_DATA_W-1:0] timer_rdata_i,
  output soc_pkg::bus_rsp_t      rsp_o
);

  soc_pkg::dev_sel_t sel_q;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      sel_q <= '0;
    end else begin
      sel_q <= dev_sel_i;
    end
  end

  // One-hot select, so an AND-OR merge is enough
  always_comb begin
    rsp_o       = '0;
    rsp_o.valid = |sel_q;
    rsp_o.err   = sel_q.unmapped;
    rsp_o.rdata = ({`SOC_DATA_W{sel_q.ram}}   & ram_rdata_i)
                | ({`SOC_DATA_W{sel_q.gpio}}  & gpio_rdata_i)
                | ({`SOC_DATA_W{sel_q.timer}} & timer_rdata_i);
  end

endmodule

//--- demo_soc_top.sv
// Demo peripheral subsystem top level
// Host port -> address decoder -> RAM, GPIO, timer -> response stage

`include "soc_params.svh"

module demo_soc_top (
  input  logic                  clk_sys_i,
  input  logic                  rst_sys_ni,
  input  logic                  host_req_i,
  input  soc_pkg::bus_req_t     host_cmd_i,
  output soc_pkg::bus_rsp_t     host_rsp_o,
  input  logic [`SOC_GPI_W-1:0] gp_i,
  output logic [`SOC_GPO_W-1:0] gp_o,
  output logic                  timer_irq_o
);

  soc_pkg::dev_sel_t      dev_sel;
  logic [`SOC_DATA_W-1:0] ram_rdata;
  logic [`SOC_DATA_W-1:0] gpio_rdata;
  logic [`SOC_DATA_W-1:0] timer_rdata;

  soc_addr_decode u_decode (
    .host_req_i (host_req_i),
    .host_cmd_i (host_cmd_i),
    .dev_sel_o  (dev_sel)
  );

  soc_ram u_ram (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_sel.ram),
    .cmd_i      (host_cmd_i),
    .rdata_o    (ram_rdata)
  );

  soc_gpio u_gpio (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_sel.gpio),
    .cmd_i      (host_cmd_i),
    .gp_i       (gp_i),
    .gp_o       (gp_o),
    .rdata_o    (gpio_rdata)
  );

  soc_timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (dev_sel.timer),
    .cmd_i      (host_cmd_i),
    .rdata_o    (timer_rdata),
    .irq_o      (timer_irq_o)
  );

  soc_rsp_mux u_rsp (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .dev_sel_i     (dev_sel),
    .ram_rdata_i   (ram_rdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .rsp_o         (host_rsp_o)
  );

endmodule

//--- demo_soc_tb_assert.sv
// Protocol checks on the host response and the timer interrupt
// Bound into the subsystem top level

`include "soc_params.svh"

module demo_soc_tb_assert (
  input logic                   clk_sys_i,
  input logic                   rst_sys_ni,
  input logic                   host_req_i,
  input soc_pkg::bus_rsp_t      host_rsp_i,
  input logic                   timer_irq_i,
  input logic [`SOC_DATA_W-1:0] mtimecmp_i
);

  rsp_after_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_req_i |=> host_rsp_i.valid)
    else $error("response valid missing one cycle after a request");

  rsp_needs_req: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rsp_i.valid |-> $past(host_req_i))
    else $error("response valid without a request in the previous cycle");

  // Unmapped answers carry no device data
  err_with_valid: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    host_rsp_i.err |-> host_rsp_i.valid && host_rsp_i.rdata == '0)
    else $error("error flag set without response valid or with nonzero read data");

  // Compare value at reset never fires
  irq_quiet: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
    (&mtimecmp_i) |-> !timer_irq_i)
    else $error("timer interrupt high while mtimecmp is all ones");

endmodule

bind demo_soc_top demo_soc_tb_assert u_tb_assert (
  .clk_sys_i   (clk_sys_i),
  .rst_sys_ni  (rst_sys_ni),
  .host_req_i  (host_req_i),
  .host_rsp_i  (host_rsp_o),
  .timer_irq_i (timer_irq_o),
  .mtimecmp_i  (u_timer.mtimecmp_q)
);

//--- demo_soc_tb.sv
// Testbench for the demo peripheral subsystem
// Random RAM traffic, GPIO, unmapped and timer accesses against a reference model

`include "soc_params.svh"

module demo_soc_tb;

  localparam int NumAddr       = 24;
  localparam int StimCycles    = 5 + 3 * NumAddr + 55;
  localparam int TimeoutCycles = StimCycles * 3 / 2;

  typedef struct packed {
    soc_pkg::bus_rsp_t rsp;
    logic              min_only;  // Data is a lower bound
    int                due;
  } exp_t;

  logic                  clk_sys;
  logic                  rst_sys_n;
  logic                  host_req;
  soc_pkg::bus_req_t     host_cmd;
  soc_pkg::bus_rsp_t     host_rsp;
  logic [`SOC_GPI_W-1:0] gp_in;
  logic [`SOC_GPO_W-1:0] gp_out;
  logic                  timer_irq;

  exp_t                  exp_q[$];
  int                    cyc = 0;
  int                    err_cnt = 0;
  logic [31:0]           rng_state = 32'heaad_e818;
  logic [31:0]           ram_addr [NumAddr];
  logic [31:0]           ram_model [256];
  logic [`SOC_GPO_W-1:0] gpo_model = '0;
  logic [`SOC_GPI_W-1:0] gpi_model = '0;
  logic [31:0]           mtime_model = '0;
  logic [31:0]           cmp_model = '1;

  demo_soc_top dut0 (
    .clk_sys_i   (clk_sys),
    .rst_sys_ni  (rst_sys_n),
    .host_req_i  (host_req),
    .host_cmd_i  (host_cmd),
    .host_rsp_o  (host_rsp),
    .gp_i        (gp_in),
    .gp_o        (gp_out),
    .timer_irq_o (timer_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #10 clk_sys = ~clk_sys;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                              input logic [3:0] be);
    logic [31:0] m;
    m = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~m) | (new_w & m);
  endfunction

  // Address map plus RAM, GPIO and timer register model
  function automatic soc_pkg::bus_rsp_t ref_access(input soc_pkg::bus_req_t cmd);
    soc_pkg::bus_rsp_t rsp;
    logic [11:0]       ofs;
    rsp       = '0;
    rsp.valid = 1'b1;
    ofs       = cmd.addr[11:0];
    if ((cmd.addr & `SOC_RAM_MASK) == `SOC_RAM_BASE) begin
      if (cmd.we) begin
        ram_model[cmd.addr[9:2]] = merge_bytes(ram_model[cmd.addr[9:2]], cmd.wdata, cmd.be);
      end else begin
        rsp.rdata = ram_model[cmd.addr[9:2]];
      end
    end else if ((cmd.addr & `SOC_GPIO_MASK) == `SOC_GPIO_BASE) begin
      if (cmd.we && ofs == 12'h000) begin
        gpo_model = `SOC_GPO_W'(merge_bytes({16'h0, gpo_model}, cmd.wdata, cmd.be));
      end else if (!cmd.we && ofs == 12'h000) begin
        rsp.rdata = {16'h0, gpo_model};
      end else if (!cmd.we && ofs == 12'h004) begin
        rsp.rdata = {24'h0, gpi_model};
      end
    end else if ((cmd.addr & `SOC_TIMER_MASK) == `SOC_TIMER_BASE) begin
      if (cmd.we && ofs == 12'h000)       mtime_model = merge_bytes(mtime_model, cmd.wdata, cmd.be);
      else if (cmd.we && ofs == 12'h004)  cmp_model = merge_bytes(cmp_model, cmd.wdata, cmd.be);
      else if (!cmd.we && ofs == 12'h000) rsp.rdata = mtime_model;
      else if (!cmd.we && ofs == 12'h004) rsp.rdata = cmp_model;
    end else begin
      rsp.err = 1'b1;
    end
    return rsp;
  endfunction

  task automatic send(input logic [31:0] addr, input logic we, input logic [3:0] be,
                      input logic [31:0] wdata);
    soc_pkg::bus_req_t cmd;
    exp_t              e;
    @(posedge clk_sys);
    cmd.addr   = addr;
    cmd.we     = we;
    cmd.be     = be;
    cmd.wdata  = wdata;
    host_req  <= 1'b1;
    host_cmd  <= cmd;
    e.rsp      = ref_access(cmd);
    e.min_only = !we && ((addr & `SOC_TIMER_MASK) == `SOC_TIMER_BASE) && addr[11:0] == 12'h000;
    e.due      = cyc + 2;  // Answer sampled one cycle after capture
    exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk_sys);
      host_req <= 1'b0;
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("[ERROR] %s expected %h got %h", name, exp, act);
    err_cnt++;
  endtask

  always @(posedge clk_sys) begin
    cyc <= cyc + 1;
    if (cyc >= TimeoutCycles) begin
      $display("Timeout: run did not complete within %0d cycles, %0d errors", cyc, err_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  // Response checker, sampled mid-cycle
  always @(negedge clk_sys) begin
    exp_t e;
    if (rst_sys_n && host_rsp.valid) begin
      if (exp_q.size() == 0) begin
        $display("Response seen in cycle %0d with no request outstanding", cyc);
        err_cnt++;
      end else begin
        e = exp_q.pop_front();
        if (e.due != cyc) begin
          $display("Response came in cycle %0d but was due in cycle %0d", cyc, e.due);
          err_cnt++;
        end
        if (host_rsp.err !== e.rsp.err) report_mismatch("host_rsp_o.err", e.rsp.err, host_rsp.err);
        if (e.min_only) begin
          if ($isunknown(host_rsp.rdata) || host_rsp.rdata < e.rsp.rdata)
            report_mismatch("host_rsp_o.rdata (lower bound)", e.rsp.rdata, host_rsp.rdata);
        end else if (host_rsp.rdata !== e.rsp.rdata) begin
          report_mismatch("host_rsp_o.rdata", e.rsp.rdata, host_rsp.rdata);
        end
      end
    end else if (rst_sys_n && exp_q.size() != 0 && exp_q[0].due <= cyc) begin
      e = exp_q.pop_front();
      $display("No response for the request due in cycle %0d", e.due);
      err_cnt++;
    end
  end

  initial begin
    logic [31:0] a;
    rst_sys_n = 1'b0;
    host_req  = 1'b0;
    host_cmd  = '0;
    gp_in     = '0;
    repeat (5) @(posedge clk_sys);
    rst_sys_n <= 1'b1;
    @(negedge clk_sys);
    if (host_rsp.valid !== 1'b0) report_mismatch("host_rsp_o.valid", 32'h0, host_rsp.valid);
    if (host_rsp.err !== 1'b0)   report_mismatch("host_rsp_o.err", 32'h0, host_rsp.err);
    if (gp_out !== '0)           report_mismatch("gp_o", 32'h0, gp_out);
    if (timer_irq !== 1'b0)      report_mismatch("timer_irq_o", 32'h0, timer_irq);

    // RAM: full writes, partial writes, reads, all back to back
    for (int i = 0; i < NumAddr; i++) ram_addr[i] = `SOC_RAM_BASE | {next_rand() & 32'h3fc};
    for (int i = 0; i < NumAddr; i++) send(ram_addr[i], 1'b1, 4'hf, next_rand());
    for (int i = 0; i < NumAddr; i++) send(ram_addr[i], 1'b1, next_rand() & 4'hf, next_rand());
    for (int i = 0; i < NumAddr; i++) send(ram_addr[i], 1'b0, 4'hf, 32'h0);
    idle(2);

    // Unmapped, one of them aliasing a RAM word
    a = ram_addr[0];
    send(32'h0010_0400 | (a & 32'h3fc), 1'b1, 4'hf, ~next_rand());
    send(32'h4000_0000, 1'b0, 4'hf, 32'h0);
    send(a, 1'b0, 4'hf, 32'h0);
    idle(2);

    send(`SOC_GPIO_BASE, 1'b1, 4'hf, next_rand());
    send(`SOC_GPIO_BASE, 1'b1, 4'b0010, next_rand());
    idle(1);
    @(negedge clk_sys);
    if (gp_out !== gpo_model) report_mismatch("gp_o", gpo_model, gp_out);
    send(`SOC_GPIO_BASE, 1'b0, 4'hf, 32'h0);
    send(`SOC_GPIO_BASE + 32'h4, 1'b0, 4'hf, 32'h0);
    @(posedge clk_sys);
    host_req <= 1'b0;
    gpi_model = `SOC_GPI_W'(next_rand());
    gp_in    <= gpi_model;
    idle(3);  // Sync delay
    send(`SOC_GPIO_BASE + 32'h4, 1'b0, 4'hf, 32'h0);
    idle(2);

    send(`SOC_TIMER_BASE + 32'h4, 1'b1, 4'hf, 32'h0001_0000);
    idle(1);
    repeat (10) begin
      @(negedge clk_sys);
      if (timer_irq !== 1'b0) report_mismatch("timer_irq_o", 32'h0, timer_irq);
    end
    send(`SOC_TIMER_BASE + 32'h4, 1'b0, 4'hf, 32'h0);
    send(`SOC_TIMER_BASE, 1'b1, 4'hf, 32'h0001_0040);
    idle(1);
    for (int k = 0; k < 2 && timer_irq !== 1'b1; k++) @(negedge clk_sys);
    if (timer_irq !== 1'b1) begin
      $display("timer_irq_o did not rise within two cycles of the mtime write");
      err_cnt++;
    end
    repeat (5) begin
      @(negedge clk_sys);
      if (timer_irq !== 1'b1) report_mismatch("timer_irq_o", 32'h1, timer_irq);
    end
    send(`SOC_TIMER_BASE, 1'b0, 4'hf, 32'h0);
    idle(3);

    while (exp_q.size() != 0) @(negedge clk_sys);
    @(negedge clk_sys);
    $display("Run complete: %0d errors", err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- demo_soc_top.f
+incdir+.
soc_pkg.sv
soc_addr_decode.sv
soc_ram.sv
soc_gpio.sv
soc_timer.sv
soc_rsp_mux.sv
demo_soc_top.sv
demo_soc_tb_assert.sv
demo_soc_tb.sv
